// ==== build.f ====
+incdir+include
rtl/sccb_pkg.sv
rtl/ov5640_pkg.sv
rtl/init_sequencer.sv
rtl/reg_table.sv
rtl/ov5640_init_top.sv
tb/tb_ov5640_init.sv

// ==== include/ov5640_cfg.svh ====
`ifndef OV5640_CFG_SVH
`define OV5640_CFG_SVH

// wait after reset before the first sccb access
// 5000 cycles of the 250 kHz clk, about 20 ms
`define OV5640_INIT_DELAY 5000

// entries in the register table
`define OV5640_REG_NUM 64

// chip id reads at the head of the table
`define OV5640_READ_NUM 2

`endif

// ==== rtl/init_sequencer.sv ====
`timescale 1ns/1ps
`include "ov5640_cfg.svh"

module init_sequencer import sccb_pkg::*, ov5640_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i2c_done,
    output tbl_idx_t  step,
    output logic      i2c_exec,
    output sccb_dir_e i2c_rh_wl,
    output logic      init_done
);

    localparam int       DLY_W    = $clog2(`OV5640_INIT_DELAY + 1);
    localparam tbl_idx_t TBL_END  = tbl_idx_t'(`OV5640_REG_NUM);
    localparam tbl_idx_t READ_END = tbl_idx_t'(`OV5640_READ_NUM);

    seq_state_e       state;
    logic [DLY_W-1:0] dly_cnt;
    tbl_idx_t         step_nxt;

    assign step_nxt = step + 1'b1;

    // sensor needs ~20 ms after power-up before the first access,
    // then one command at a time, each released by the master's done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_POWER_WAIT;
            dly_cnt   <= '0;
            step      <= '0;
            i2c_exec  <= 1'b0;
            i2c_rh_wl <= DIR_READ;  // table starts with chip id reads
            init_done <= 1'b0;
        end else begin
            i2c_exec <= 1'b0;  // exec is a single cycle pulse

            case (state)
                ST_POWER_WAIT: begin
                    if (dly_cnt == DLY_W'(`OV5640_INIT_DELAY)) begin
                        i2c_exec <= 1'b1;
                        state    <= ST_ISSUE;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end

                ST_ISSUE: begin
                    step  <= step_nxt;  // table word follows one cycle later
                    state <= ST_WAIT_DONE;
                    // past the id reads everything is a write
                    if (step_nxt >= READ_END)
                        i2c_rh_wl <= DIR_WRITE;
                end

                ST_WAIT_DONE: begin
                    if (i2c_done) begin
                        if (step == TBL_END) begin
                            init_done <= 1'b1;  // last entry acknowledged
                            state     <= ST_FINISHED;
                        end else begin
                            i2c_exec <= 1'b1;
                            state    <= ST_ISSUE;
                        end
                    end
                end

                default: begin
                    state <= ST_FINISHED;  // terminal, stray done ignored
                end
            endcase
        end
    end

endmodule

// ==== rtl/ov5640_init_top.sv ====
`timescale 1ns/1ps

module ov5640_init_top import sccb_pkg::*, ov5640_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i2c_done,       // master finished the last command
    input  frame_dim_t cmos_h_pixel,   // output width
    input  frame_dim_t cmos_v_pixel,   // output height
    input  frame_dim_t total_h_pixel,  // line length incl. blanking
    input  frame_dim_t total_v_pixel,  // frame length incl. blanking
    output logic       i2c_exec,
    output sccb_cmd_t  i2c_data,
    output logic       i2c_rh_wl,      // 1 read, 0 write
    output logic       init_done
);

    tbl_idx_t step;

    // walks the table under the master's handshake
    init_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2c_done  (i2c_done),
        .step      (step),
        .i2c_exec  (i2c_exec),
        .i2c_rh_wl (i2c_rh_wl),
        .init_done (init_done)
    );

    // address/value lookup
    reg_table u_tbl (
        .clk           (clk),
        .rst_n         (rst_n),
        .step          (step),
        .cmos_h_pixel  (cmos_h_pixel),
        .cmos_v_pixel  (cmos_v_pixel),
        .total_h_pixel (total_h_pixel),
        .total_v_pixel (total_v_pixel),
        .i2c_data      (i2c_data)
    );

endmodule

// ==== rtl/ov5640_pkg.sv ====
package ov5640_pkg;

    localparam int FRAME_DIM_W = 13;  // up to 8191 pixels or lines
    localparam int TBL_IDX_W   = 8;

    // pixel or line count for the output and total frame size
    typedef logic [FRAME_DIM_W-1:0] frame_dim_t;

    // position in the register table
    typedef logic [TBL_IDX_W-1:0] tbl_idx_t;

    // init sequencer states
    typedef enum logic [1:0] {
        ST_POWER_WAIT = 2'd0,  // power-up delay
        ST_ISSUE      = 2'd1,  // exec pulse out, index steps
        ST_WAIT_DONE  = 2'd2,  // command in flight
        ST_FINISHED   = 2'd3   // whole table sent
    } seq_state_e;

endpackage

// ==== rtl/reg_table.sv ====
`timescale 1ns/1ps

module reg_table import sccb_pkg::*, ov5640_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  tbl_idx_t   step,
    input  frame_dim_t cmos_h_pixel,
    input  frame_dim_t cmos_v_pixel,
    input  frame_dim_t total_h_pixel,
    input  frame_dim_t total_v_pixel,
    output sccb_cmd_t  i2c_data
);

    // chip id high read for any index past the table
    localparam sccb_cmd_t CHIP_ID_H = {16'h300a, 8'h00};

    sccb_cmd_t tbl_word;

    always_comb begin
        case (step)
            // chip id, read back only
            8'd0  : tbl_word = {16'h300a, 8'h00};
            8'd1  : tbl_word = {16'h300b, 8'h00};
            // soft reset, then normal mode
            8'd2  : tbl_word = {16'h3008, 8'h82};
            8'd3  : tbl_word = {16'h3008, 8'h02};
            8'd4  : tbl_word = {16'h3103, 8'h02};  // system clock from pll
            // pad output enables
            8'd5  : tbl_word = {16'h3017, 8'hff};  // frex, vsync, href, pclk, d[9:6]
            8'd6  : tbl_word = {16'h3018, 8'hff};  // d[5:0], gpio
            8'd7  : tbl_word = {16'h3037, 8'h13};  // pll pre-divider
            8'd8  : tbl_word = {16'h3108, 8'h01};  // root divider
            // analog and sensor core tuning
            8'd9  : tbl_word = {16'h3630, 8'h36};
            8'd10 : tbl_word = {16'h3631, 8'h0e};
            8'd11 : tbl_word = {16'h3632, 8'he2};
            8'd12 : tbl_word = {16'h3633, 8'h12};
            8'd13 : tbl_word = {16'h3621, 8'he0};
            8'd14 : tbl_word = {16'h3704, 8'ha0};
            8'd15 : tbl_word = {16'h3703, 8'h5a};
            8'd16 : tbl_word = {16'h3715, 8'h78};
            8'd17 : tbl_word = {16'h3717, 8'h01};
            8'd18 : tbl_word = {16'h370b, 8'h60};
            8'd19 : tbl_word = {16'h3705, 8'h1a};
            8'd20 : tbl_word = {16'h3905, 8'h02};
            8'd21 : tbl_word = {16'h3906, 8'h10};
            8'd22 : tbl_word = {16'h3901, 8'h0a};
            8'd23 : tbl_word = {16'h3731, 8'h12};
            8'd24 : tbl_word = {16'h302d, 8'h60};  // system control
            8'd25 : tbl_word = {16'h3000, 8'h00};  // release block resets
            8'd26 : tbl_word = {16'h3004, 8'hff};  // all clocks on
            // rgb565 out of the isp
            8'd27 : tbl_word = {16'h4300, 8'h61};
            8'd28 : tbl_word = {16'h501f, 8'h01};
            8'd29 : tbl_word = {16'h3035, 8'h11};  // system clock divider
            8'd30 : tbl_word = {16'h3036, 8'h3c};  // pll multiplier
            // mirror and flip
            8'd31 : tbl_word = {16'h3820, 8'h41};
            8'd32 : tbl_word = {16'h3821, 8'h07};
            // subsampling, x and y
            8'd33 : tbl_word = {16'h3814, 8'h31};
            8'd34 : tbl_word = {16'h3815, 8'h31};
            // sensor window start and end
            8'd35 : tbl_word = {16'h3800, 8'h00};
            8'd36 : tbl_word = {16'h3801, 8'h00};
            8'd37 : tbl_word = {16'h3802, 8'h00};
            8'd38 : tbl_word = {16'h3803, 8'h04};
            8'd39 : tbl_word = {16'h3804, 8'h0a};
            8'd40 : tbl_word = {16'h3805, 8'h3f};
            8'd41 : tbl_word = {16'h3806, 8'h07};
            8'd42 : tbl_word = {16'h3807, 8'h9b};
            // dvp output size
            8'd43 : tbl_word = {16'h3808, 4'd0, cmos_h_pixel[11:8]};
            8'd44 : tbl_word = {16'h3809, cmos_h_pixel[7:0]};
            8'd45 : tbl_word = {16'h380a, 5'd0, cmos_v_pixel[10:8]};
            8'd46 : tbl_word = {16'h380b, cmos_v_pixel[7:0]};
            // total line length and frame length
            8'd47 : tbl_word = {16'h380c, 3'd0, total_h_pixel[12:8]};
            8'd48 : tbl_word = {16'h380d, total_h_pixel[7:0]};
            8'd49 : tbl_word = {16'h380e, 3'd0, total_v_pixel[12:8]};
            8'd50 : tbl_word = {16'h380f, total_v_pixel[7:0]};
            // window offsets
            8'd51 : tbl_word = {16'h3810, 8'h00};
            8'd52 : tbl_word = {16'h3811, 8'h10};
            8'd53 : tbl_word = {16'h3812, 8'h00};
            8'd54 : tbl_word = {16'h3813, 8'h06};
            8'd55 : tbl_word = {16'h3618, 8'h00};
            8'd56 : tbl_word = {16'h3612, 8'h29};
            8'd57 : tbl_word = {16'h3709, 8'h52};
            8'd58 : tbl_word = {16'h370c, 8'h03};
            8'd59 : tbl_word = {16'h3824, 8'h02};  // dvp pclk divider
            8'd60 : tbl_word = {16'h460c, 8'h22};
            8'd61 : tbl_word = {16'h4837, 8'h22};  // pclk period
            8'd62 : tbl_word = {16'h5001, 8'ha3};  // isp control
            // test pattern off (8'h80 for colour bars)
            8'd63 : tbl_word = {16'h503d, 8'h00};
            default: tbl_word = CHIP_ID_H;
        endcase
    end

    // registered so the word is stable well before the next exec
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            i2c_data <= '0;
        else
            i2c_data <= tbl_word;
    end

endmodule

// ==== rtl/sccb_pkg.sv ====
package sccb_pkg;

    // one command word for the sccb master
    // upper 16 bits register address, lower 8 bits value
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;  // ignored by the master on reads
    } sccb_cmd_t;

    // transfer direction, matches the master's rh_wl input
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } sccb_dir_e;

endpackage

// ==== tb/tb_ov5640_init.sv ====
`timescale 1ns/1ps
`include "ov5640_cfg.svh"

module tb_ov5640_init import sccb_pkg::*, ov5640_pkg::*; ();

    // one output size set per test
    typedef struct packed {
        frame_dim_t out_h;
        frame_dim_t out_v;
        frame_dim_t tot_h;
        frame_dim_t tot_v;
    } size_set_t;

    localparam int NUM_SETS   = 3;
    localparam int IDLE_CHECK = 20;  // cycles watched after init_done
    localparam int CYCLE_LIMIT =
        NUM_SETS * (`OV5640_INIT_DELAY + `OV5640_REG_NUM * 10 + 100);

    localparam size_set_t SIZE_TBL [0:NUM_SETS-1] = '{
        '{13'd640,  13'd480, 13'd1892, 13'd740},
        '{13'd1280, 13'd720, 13'd2200, 13'd750},
        '{13'd800,  13'd600, 13'd1956, 13'd1018}
    };

    // sensor register commands in sequence order
    // frame size values (3808..380f) stay zero here and are filled per size set
    localparam logic [23:0] BASE_CMD [0:`OV5640_REG_NUM-1] = '{
        24'h300a00, 24'h300b00, 24'h300882, 24'h300802,  // id reads, soft reset
        24'h310302, 24'h3017ff, 24'h3018ff, 24'h303713,
        24'h310801, 24'h363036, 24'h36310e, 24'h3632e2,
        24'h363312, 24'h3621e0, 24'h3704a0, 24'h37035a,
        24'h371578, 24'h371701, 24'h370b60, 24'h37051a,
        24'h390502, 24'h390610, 24'h39010a, 24'h373112,
        24'h302d60, 24'h300000, 24'h3004ff, 24'h430061,
        24'h501f01, 24'h303511, 24'h30363c, 24'h382041,
        24'h382107, 24'h381431, 24'h381531, 24'h380000,  // mirror, subsample, window
        24'h380100, 24'h380200, 24'h380304, 24'h38040a,
        24'h38053f, 24'h380607, 24'h38079b, 24'h380800,
        24'h380900, 24'h380a00, 24'h380b00, 24'h380c00,
        24'h380d00, 24'h380e00, 24'h380f00, 24'h381000,
        24'h381110, 24'h381200, 24'h381306, 24'h361800,
        24'h361229, 24'h370952, 24'h370c03, 24'h382402,
        24'h460c22, 24'h483722, 24'h5001a3, 24'h503d00   // test pattern off
    };

    logic       clk = 1'b0;
    logic       rst_n;
    logic       i2c_done;
    frame_dim_t cmos_h_pixel;
    frame_dim_t cmos_v_pixel;
    frame_dim_t total_h_pixel;
    frame_dim_t total_v_pixel;
    logic       i2c_exec;
    sccb_cmd_t  i2c_data;
    logic       i2c_rh_wl;
    logic       init_done;

    logic [23:0] ref_cmd [0:`OV5640_REG_NUM-1];
    integer      seed = 33017;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          pass_cnt  = 0;
    int          cyc_total = 0;

    ov5640_init_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i2c_done      (i2c_done),
        .cmos_h_pixel  (cmos_h_pixel),
        .cmos_v_pixel  (cmos_v_pixel),
        .total_h_pixel (total_h_pixel),
        .total_v_pixel (total_v_pixel),
        .i2c_exec      (i2c_exec),
        .i2c_data      (i2c_data),
        .i2c_rh_wl     (i2c_rh_wl),
        .init_done     (init_done)
    );

    always #50 clk = ~clk;  // 100 ns period

    // run limit
    always @(posedge clk) begin
        cyc_total = cyc_total + 1;
        if (cyc_total >= CYCLE_LIMIT) begin
            $display("timeout: init sequence did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // sccb master model answering each exec after 1 to 8 cycles
    initial begin
        int wait_cyc;
        i2c_done = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && i2c_exec === 1'b1) begin
                wait_cyc = 1 + ($unsigned($random(seed)) % 8);
                repeat (wait_cyc) @(posedge clk);
                #1 i2c_done = 1'b1;
                @(posedge clk);
                #1 i2c_done = 1'b0;
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_fault(input string msg);
        err_cnt++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    function automatic logic expected_dir(input int idx);
        return (idx < `OV5640_READ_NUM) ? DIR_READ : DIR_WRITE;
    endfunction

    // fixed entries plus frame size bytes sliced from the inputs
    function automatic void build_expected(input size_set_t s);
        int i;
        for (i = 0; i < `OV5640_REG_NUM; i++) begin
            ref_cmd[i] = BASE_CMD[i];
            case (BASE_CMD[i][23:8])
                16'h3808: ref_cmd[i][7:0] = {4'd0, s.out_h[11:8]};
                16'h3809: ref_cmd[i][7:0] = s.out_h[7:0];
                16'h380a: ref_cmd[i][7:0] = {5'd0, s.out_v[10:8]};
                16'h380b: ref_cmd[i][7:0] = s.out_v[7:0];
                16'h380c: ref_cmd[i][7:0] = {3'd0, s.tot_h[12:8]};
                16'h380d: ref_cmd[i][7:0] = s.tot_h[7:0];
                16'h380e: ref_cmd[i][7:0] = {3'd0, s.tot_v[12:8]};
                16'h380f: ref_cmd[i][7:0] = s.tot_v[7:0];
                default: ;
            endcase
        end
    endfunction

    // 8 cycles of reset with outputs checked before release
    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        check_val("i2c_exec", i2c_exec, 1'b0);
        check_val("init_done", init_done, 1'b0);
        check_val("i2c_rh_wl", i2c_rh_wl, DIR_READ);
        check_val("i2c_data", i2c_data, 24'h0);
        rst_n = 1'b1;
    endtask

    task automatic run_sequence(input int t);
        size_set_t s;
        int        cyc;
        int        n_exec;
        int        last_done;
        int        err_start;
        bit        done_seen;
        bit        finished;
        s         = SIZE_TBL[t];
        err_start = err_cnt;
        @(posedge clk);
        #1;
        cmos_h_pixel  = s.out_h;
        cmos_v_pixel  = s.out_v;
        total_h_pixel = s.tot_h;
        total_v_pixel = s.tot_v;
        build_expected(s);
        apply_reset();
        @(posedge clk);  // first edge out of reset
        cyc       = 0;
        n_exec    = 0;
        last_done = 0;
        done_seen = 1'b0;
        finished  = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cyc++;
            if (i2c_exec === 1'b1) begin
                if (n_exec == 0)
                    check_val("first_exec_delay", cyc - 1, `OV5640_INIT_DELAY);
                else if (!done_seen)
                    report_fault($sformatf("exec %0d came before done of the previous one",
                                           n_exec));
                if (n_exec >= `OV5640_REG_NUM) begin
                    report_fault("exec pulse past the end of the table");
                end else begin
                    check_val("i2c_data", i2c_data, ref_cmd[n_exec]);
                    check_val("i2c_rh_wl", i2c_rh_wl, expected_dir(n_exec));
                end
                n_exec++;
                done_seen = 1'b0;
            end
            if (i2c_done === 1'b1) begin
                done_seen = 1'b1;
                last_done = cyc;
            end
            if (init_done === 1'b1)
                finished = 1'b1;
        end
        check_val("exec_count", n_exec, `OV5640_REG_NUM);
        check_val("init_done_latency", cyc - last_done, 1);
        if (!done_seen)
            report_fault("init_done rose before the last command was answered");
        // master idle so the table must stay finished
        repeat (IDLE_CHECK) begin
            @(negedge clk);
            if (i2c_exec !== 1'b0)
                report_fault("exec pulse after init_done");
            check_val("init_done", init_done, 1'b1);
            check_val("i2c_data", i2c_data, 24'h300a00);  // past the table, chip id high
        end
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("test %0d: %0dx%0d in %0dx%0d, %0d commands, ok",
                     t, s.out_h, s.out_v, s.tot_h, s.tot_v, n_exec);
        end else begin
            $display("test %0d: %0dx%0d in %0dx%0d, %0d errors",
                     t, s.out_h, s.out_v, s.tot_h, s.tot_v, err_cnt - err_start);
        end
    endtask

    initial begin
        int t;
        rst_n         = 1'b0;
        cmos_h_pixel  = '0;
        cmos_v_pixel  = '0;
        total_h_pixel = '0;
        total_v_pixel = '0;
        for (t = 0; t < NUM_SETS; t++)
            run_sequence(t);
        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 NUM_SETS, pass_cnt, NUM_SETS - pass_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
